// ==== dv/fas_checker.sv ====
// checker for the filter front end, reference model of FIR and framing with output compare
`timescale 1ns/1ns
`default_nettype none

module fas_checker (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,   // DUT inputs, stable at the rising edge
  input  fas_pkg::sample_t data,
  input  logic             fir_valid,    // DUT outputs, compared at the falling edge
  input  fas_pkg::sample_t fir_d,
  input  logic             frame_valid,
  input  fas_pkg::frame_t  frame_d,
  output int               errors        // running mismatch count
);

  ////////////////////////////////////////////////////////////
  // model state
  ////////////////////////////////////////////////////////////

  int               hist [fas_pkg::num_taps];  // hist[k] = x(n-k)
  int               fill;                      // accepted samples since last gap
  int               lane;                      // next lane of the frame model
  int               err_count = 0;
  logic             exp_fir_valid;
  fas_pkg::sample_t exp_fir_d;
  logic             exp_frame_valid;
  fas_pkg::frame_t  exp_frame_d;
  fas_pkg::frame_t  stage;                     // partial frame of predicted words

  assign errors = err_count;

  // sum of products over the window, then Q24 to Q8 with +1 on negative sums
  function automatic fas_pkg::sample_t expected_word();
    longint acc;
    longint scaled;
    acc = 0;
    for (int k = 0; k < fas_pkg::num_taps; k++) begin
      acc += longint'(hist[k]) * longint'(fas_pkg::fir_coefs[k]);  // both sign extended
    end
    scaled = acc >>> fas_pkg::out_shift;
    if (acc < 0) begin
      scaled = scaled + 1;
    end
    return scaled[fas_pkg::sample_width-1:0];  // wraps like the 16-bit register
  endfunction

  ////////////////////////////////////////////////////////////
  // prediction, one step per rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < fas_pkg::num_taps; k++) begin
        hist[k] = 0;
      end
      fill            = 0;
      lane            = 0;
      exp_fir_valid   = 1'b0;
      exp_fir_d       = '0;
      exp_frame_valid = 1'b0;
      exp_frame_d     = '0;
      stage           = '0;
    end else begin
      // framing first: the collector sees the word registered at the previous edge
      exp_frame_valid = 1'b0;
      if (exp_fir_valid) begin
        stage[lane] = exp_fir_d;
        if (lane == fas_pkg::frame_len - 1) begin
          exp_frame_d     = stage;  // all 16 lanes written in this run
          exp_frame_valid = 1'b1;
          lane            = 0;
        end else begin
          lane++;
        end
      end else begin
        lane = 0;  // partial frame dropped
      end
      // filter step
      if (data_valid) begin
        for (int k = fas_pkg::num_taps - 1; k > 0; k--) begin
          hist[k] = hist[k-1];
        end
        hist[0] = data;
        if (fill < fas_pkg::num_taps) fill++;  // saturates at 32
        exp_fir_valid = (fill == fas_pkg::num_taps);
        exp_fir_d     = expected_word();
      end else begin
        fill          = 0;     // history kept, only the count restarts
        exp_fir_valid = 1'b0;  // fir_d holds its last value
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // compare, half a cycle after each edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (fir_valid !== exp_fir_valid) begin
      $display("ERROR at %0t ns: fir_valid expected %0b, got %0b",
               $time, exp_fir_valid, fir_valid);
      err_count++;
    end
    if (fir_d !== exp_fir_d) begin
      $display("ERROR at %0t ns: fir_d expected %0d, got %0d", $time, exp_fir_d, fir_d);
      err_count++;
    end
    if (frame_valid !== exp_frame_valid) begin
      $display("ERROR at %0t ns: frame_valid expected %0b, got %0b",
               $time, exp_frame_valid, frame_valid);
      err_count++;
    end
    if (frame_d !== exp_frame_d) begin
      $display("ERROR at %0t ns: frame_d expected %h, got %h", $time, exp_frame_d, frame_d);
      err_count++;
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_fas.sv ====
// testbench top with clock, reset, segment table, stimulus loop, timeout and summary
`timescale 1ns/1ns
`default_nettype none

module tb_fas;

  logic             clk;
  logic             rst;
  logic             data_valid;
  fas_pkg::sample_t data;
  logic             fir_valid;
  fas_pkg::sample_t fir_d;
  logic             frame_valid;
  fas_pkg::frame_t  frame_d;
  int               errors;

  int seed   = 25561;  // random stream seed
  int cycles = 0;
  int limit  = 0;      // set from the table before reset ends

  ////////////////////////////////////////////////////////////
  // segment table: name, pattern kind, amplitude, samples, gap cycles
  ////////////////////////////////////////////////////////////

  string row_name [6] = '{"impulse", "constant", "alternating", "random_gap",
                          "random_short", "negative_constant"};
  string row_kind [6] = '{"impulse", "constant", "alternating", "random",
                          "random", "constant"};
  int    row_amp  [6] = '{256, 1000, 3000, 8000, 8000, -1500};
  int    row_len  [6] = '{64, 96, 96, 80, 20, 64};  // short random row never fills 32 taps
  int    row_gap  [6] = '{3, 2, 1, 1, 2, 4};

  fas_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame_d     (frame_d)
  );

  fas_checker i_checker (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame_d     (frame_d),
    .errors      (errors)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // sample idx of a segment, impulse sits once the taps are full
  function automatic fas_pkg::sample_t pattern_sample(input string kind, input int amp,
                                                      input int idx);
    int v;
    if (kind == "impulse") v = (idx == 32) ? amp : 0;
    else if (kind == "constant") v = amp;
    else if (kind == "alternating") v = (idx % 2 == 0) ? amp : -amp;
    else v = $random(seed) % amp;
    return fas_pkg::sample_t'(v);
  endfunction

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("run timed out after %0d cycles without finishing the table", cycles);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus loop
  ////////////////////////////////////////////////////////////

  initial begin
    int base;
    int passed;
    int failed;
    passed = 0;
    failed = 0;
    for (int r = 0; r < 6; r++) limit += row_len[r] + row_gap[r];
    limit += 100;  // reset, tail cycles and margin
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    repeat (5) @(posedge clk);
    #10 rst = 1'b0;
    @(negedge clk);
    #1;
    if (errors == 0) begin
      passed++;
      $display("reset: PASS");
    end else begin
      failed++;
      $display("reset: FAIL");
    end
    for (int r = 0; r < 6; r++) begin
      base = errors;
      for (int i = 0; i < row_len[r]; i++) begin
        @(posedge clk);
        #10;
        data_valid = 1'b1;
        data       = pattern_sample(row_kind[r], row_amp[r], i);
      end
      for (int g = 0; g < row_gap[r]; g++) begin
        @(posedge clk);
        #10;
        data_valid = 1'b0;
        data       = '0;
      end
      @(posedge clk);  // let the last frame pulse show up
      @(negedge clk);
      #1;
      if (errors == base) begin
        passed++;
        $display("%s: PASS", row_name[r]);
      end else begin
        failed++;
        $display("%s: FAIL with %0d mismatches", row_name[r], errors - base);
      end
    end
    $display("summary: %0d passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_fas -f verilog.f -o tb_fas_sim \
  && ./obj_dir/tb_fas_sim > sim.log 2>&1 \
  || { echo "build or run of the simulation did not complete"; exit 1; }

cat sim.log

grep -q "test failed" sim.log \
  && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation clean"; exit 0; }

// ==== source/fas_pkg.sv ====
// sample and frame types, filter and framing sizes, low-pass FIR coefficient table
`default_nettype none

package fas_pkg;

  ////////////////////////////////////////////////////////////
  // datapath sizes
  ////////////////////////////////////////////////////////////

  localparam int sample_width = 16;  // signed Q8 in and out
  localparam int coef_width   = 20;  // signed Q16, 1.0 = 65536
  localparam int num_taps     = 32;
  localparam int acc_width    = 41;  // 36-bit products, 32 of them summed
  localparam int out_shift    = 16;  // Q24 sum back to Q8
  localparam int frame_len    = 16;  // samples per parallel frame

  // counter widths and terminal counts
  localparam int fill_width = $clog2(num_taps + 1);  // must hold num_taps itself
  localparam int lane_width = $clog2(frame_len);

  localparam logic [fill_width-1:0] full_count = fill_width'(num_taps);
  localparam logic [lane_width-1:0] last_lane  = lane_width'(frame_len - 1);

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic signed [sample_width-1:0] sample_t;

  // lane 0 holds the oldest sample of the frame
  typedef sample_t [frame_len-1:0] frame_t;

  ////////////////////////////////////////////////////////////
  // coefficients
  ////////////////////////////////////////////////////////////

  // index k weights the sample taken k valid cycles before the newest
  // symmetric about 15/16 so the response is linear phase
  localparam logic signed [coef_width-1:0] fir_coefs [num_taps] = '{
    20'hFFF9E, 20'hFFF86, 20'hFFFA7, 20'h0003B,  // outer side lobe
    20'h0014B, 20'h0024A, 20'h00222, 20'hFFFE4,
    20'hFFBC5, 20'hFF7CA, 20'hFF74E, 20'hFFD74,  // first negative lobe
    20'h00B1A, 20'h01DAC, 20'h02F9E, 20'h03AA9,  // main lobe rising
    20'h03AA9, 20'h02F9E, 20'h01DAC, 20'h00B1A,  // main lobe falling
    20'hFFD74, 20'hFF74E, 20'hFF7CA, 20'hFFBC5,
    20'hFFFE4, 20'h00222, 20'h0024A, 20'h0014B,
    20'h0003B, 20'hFFFA7, 20'hFFF86, 20'hFFF9E   // mirror of taps 0..3
  };

endpackage

`default_nettype wire

// ==== source/fas_top.sv ====
// top level of the filter front end, FIR filter feeding the frame collector
`timescale 1ns/1ns
`default_nettype none

module fas_top (
  input  logic             clk,
  input  logic             rst,

  // sample stream in, no back-pressure
  input  logic             data_valid,
  input  fas_pkg::sample_t data,

  // filtered stream, also feeds the collector
  output logic             fir_valid,
  output fas_pkg::sample_t fir_d,

  // parallel frames of 16 filtered samples
  output logic             frame_valid,
  output fas_pkg::frame_t  frame_d
);

  ////////////////////////////////////////////////////////////
  // filter
  ////////////////////////////////////////////////////////////

  fir_filter i_fir (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),  // 32 cycles after a run starts
    .fir_d      (fir_d)
  );

  ////////////////////////////////////////////////////////////
  // frame assembly
  ////////////////////////////////////////////////////////////

  frame_collector i_frame (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),  // 16 cycles after the first filter word
    .frame_d     (frame_d)
  );

endmodule

`default_nettype wire

// ==== source/fir_filter.sv ====
// 32-tap symmetric FIR filter with tap line, multiply-accumulate, Q8 rescale and fill counter
`timescale 1ns/1ns
`default_nettype none

module fir_filter (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,  // one sample per high cycle, always taken
  input  fas_pkg::sample_t data,        // signed Q8
  output logic             fir_valid,   // high once a full window of 32 has been seen
  output fas_pkg::sample_t fir_d        // filtered Q8 sample
);

  ////////////////////////////////////////////////////////////
  // storage and working signals
  ////////////////////////////////////////////////////////////

  // registered history, taps[0] is x(n-1) for the incoming sample
  fas_pkg::sample_t taps [fas_pkg::num_taps-1];

  // full 32-entry window as seen by the incoming sample
  // window[k] = x(n-k), window[0] is the sample on the data port
  fas_pkg::sample_t window [fas_pkg::num_taps];

  logic [fas_pkg::fill_width-1:0] fill_cnt;   // accepted samples since last gap
  logic [fas_pkg::fill_width-1:0] fill_next;  // saturating increment

  logic signed [fas_pkg::acc_width-1:0] acc;      // Q24 sum of products
  logic signed [fas_pkg::acc_width-1:0] acc_shr;  // acc in Q8, still full width
  logic [fas_pkg::sample_width-1:0]     round_bit;
  fas_pkg::sample_t                     fir_next;

  ////////////////////////////////////////////////////////////
  // tap window
  ////////////////////////////////////////////////////////////

  always_comb begin
    window[0] = data;  // newest sample joins the window this cycle
    for (int k = 1; k < fas_pkg::num_taps; k++) begin
      window[k] = taps[k-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // multiply-accumulate
  ////////////////////////////////////////////////////////////

  // every operand is signed, so each 16x20 product is sign extended
  // to the 41-bit accumulator before it is added
  always_comb begin
    acc = '0;
    for (int k = 0; k < fas_pkg::num_taps; k++) begin
      acc = acc + window[k] * fas_pkg::fir_coefs[k];
    end
  end

  ////////////////////////////////////////////////////////////
  // rescale to Q8
  ////////////////////////////////////////////////////////////

  assign acc_shr = acc >>> fas_pkg::out_shift;  // drop the 16 coefficient fraction bits

  // negative sums get +1 after the shift, pulling them back toward zero
  assign round_bit = {{(fas_pkg::sample_width-1){1'b0}}, acc[fas_pkg::acc_width-1]};

  assign fir_next = acc_shr[fas_pkg::sample_width-1:0] + round_bit;  // low 16 bits kept

  ////////////////////////////////////////////////////////////
  // fill counter
  ////////////////////////////////////////////////////////////

  // sticks at num_taps while the run of valid samples continues
  assign fill_next = (fill_cnt == fas_pkg::full_count) ? fill_cnt : fill_cnt + 1'b1;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt  <= '0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
      for (int k = 0; k < fas_pkg::num_taps - 1; k++) begin
        taps[k] <= '0;
      end
    end else if (data_valid) begin
      fill_cnt  <= fill_next;
      fir_valid <= (fill_next == fas_pkg::full_count);  // 32nd sample of the run or later
      fir_d     <= fir_next;
      // shift by one, window[31] falls off the end
      for (int k = 0; k < fas_pkg::num_taps - 1; k++) begin
        taps[k] <= window[k];
      end
    end else begin
      // gap in the stream
      fill_cnt  <= '0;    // next run has to refill all 32 taps
      fir_valid <= 1'b0;  // taps and fir_d are left as they are
    end
  end

endmodule

`default_nettype wire

// ==== source/frame_collector.sv ====
// serial-to-parallel frame assembly of filter outputs with a one-cycle frame strobe
`timescale 1ns/1ns
`default_nettype none

module frame_collector (
  input  logic             clk,
  input  logic             rst,
  input  logic             fir_valid,    // every high cycle carries one word
  input  fas_pkg::sample_t fir_d,
  output logic             frame_valid,  // single-cycle pulse per finished frame
  output fas_pkg::frame_t  frame_d       // lane 0 oldest, lane 15 newest
);

  ////////////////////////////////////////////////////////////
  // lane counter and staging frame
  ////////////////////////////////////////////////////////////

  logic [fas_pkg::lane_width-1:0] lane_cnt;  // lane for the next word
  fas_pkg::frame_t                stage;       // words of the frame in progress
  fas_pkg::frame_t                stage_next;  // stage with the current word dropped in

  always_comb begin
    stage_next           = stage;
    stage_next[lane_cnt] = fir_d;
  end

  always_ff @(posedge clk) begin
    if (fir_valid) begin
      stage <= stage_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // publish
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lane_cnt    <= '0;
      frame_valid <= 1'b0;
      frame_d     <= '0;
    end else begin
      frame_valid <= 1'b0;  // pulse lasts one cycle only
      if (fir_valid) begin
        if (lane_cnt == fas_pkg::last_lane) begin
          frame_d     <= stage_next;  // includes the 16th word taken this cycle
          frame_valid <= 1'b1;
          lane_cnt    <= '0;
        end else begin
          lane_cnt <= lane_cnt + 1'b1;
        end
      end else begin
        // a gap drops the partial frame
        // stale lanes in stage are all rewritten before the next publish
        lane_cnt <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/fas_pkg.sv
source/fir_filter.sv
source/frame_collector.sv
source/fas_top.sv
dv/fas_checker.sv
dv/tb_fas.sv
